// File: filelist.f
rtl/noc_flit_pkg.sv
rtl/noc_ctrl_pkg.sv
rtl/noc_rr_arbiter.sv
rtl/noc_packet_mux.sv
rtl/noc_vc_link_arbiter.sv
rtl/noc_output_port.sv
tests/noc_output_port_properties.sv
tests/tb_noc_output_port.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_noc_output_port
RTL_TOP    = noc_output_port
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No pass result in log"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		rtl/noc_flit_pkg.sv rtl/noc_ctrl_pkg.sv rtl/noc_rr_arbiter.sv \
		rtl/noc_packet_mux.sv rtl/noc_vc_link_arbiter.sv rtl/noc_output_port.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_noc_output_port.sv
// Directed testbench for the output port; CHANNELS 4, FLIT_WIDTH 32, all flit traffic from queues
`default_nettype none
`timescale 1ns/1ps

module tb_noc_output_port import noc_flit_pkg::*;;

  localparam int CH = 4;
  localparam int FW = 32;

  logic                   clk;
  logic                   rst;
  logic [CH-1:0][FW-1:0]  vc0_in_flit;
  logic [CH-1:0]          vc0_in_last;
  logic [CH-1:0]          vc0_in_valid;
  logic [CH-1:0]          vc0_in_ready;
  logic [CH-1:0][FW-1:0]  vc1_in_flit;
  logic [CH-1:0]          vc1_in_last;
  logic [CH-1:0]          vc1_in_valid;
  logic [CH-1:0]          vc1_in_ready;
  logic [FW-1:0]          out_flit;
  logic                   out_last;
  vc_id_e                 out_vc;
  logic                   out_valid;
  logic                   out_ready;

  // {last, flit} per source port, received and expected per VC
  logic [FW:0] tx_q [NUM_VC][CH][$];
  logic [FW:0] rx_q [NUM_VC][$];
  logic [FW:0] exp_q [NUM_VC][$];
  int          vc_seq [$];
  // Cycle number of each link transfer
  int          xfer_cyc [$];
  int          cycle = 0;
  logic [NUM_VC-1:0][CH-1:0] done;

  int value_errors = 0;
  int other_errors = 0;
  int seed = 32'hfb43;
  logic stall_en = 1'b0;

  noc_output_port #(.CHANNELS(CH), .FLIT_WIDTH(FW)) i_dut (.*);

  ////////////////////////////////////////
  // Clock, source driver, monitor
  ////////////////////////////////////////

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Record handshakes so the driver can pop on the next falling edge
  always @(posedge clk) begin
    if (rst) begin
      done <= '0;
    end else begin
      done[0] <= vc0_in_valid & vc0_in_ready;
      done[1] <= vc1_in_valid & vc1_in_ready;
    end
  end

  // Present each queue head, hold until accepted
  always @(negedge clk) begin
    for (int c = 0; c < CH; c++) begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (done[v][c] && tx_q[v][c].size() > 0) void'(tx_q[v][c].pop_front());
      end
      vc0_in_valid[c] = (tx_q[0][c].size() > 0);
      vc0_in_flit[c]  = vc0_in_valid[c] ? tx_q[0][c][0][FW-1:0] : '0;
      vc0_in_last[c]  = vc0_in_valid[c] ? tx_q[0][c][0][FW] : 1'b0;
      vc1_in_valid[c] = (tx_q[1][c].size() > 0);
      vc1_in_flit[c]  = vc1_in_valid[c] ? tx_q[1][c][0][FW-1:0] : '0;
      vc1_in_last[c]  = vc1_in_valid[c] ? tx_q[1][c][0][FW] : 1'b0;
    end
    out_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      rx_q[out_vc].push_back({out_last, out_flit});
      vc_seq.push_back(int'(out_vc));
      xfer_cyc.push_back(cycle);
    end
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // VC, channel, packet number and flit index in one word
  function automatic logic [FW-1:0] make_flit(int v, int c, int p, int i);
    return {4'(v), 4'(c), 8'(p), 16'(i)};
  endfunction

  // Queue at the source and record what the link should carry
  task automatic send_packet(int v, int c, int p, int len);
    for (int i = 0; i < len; i++) begin
      tx_q[v][c].push_back({(i == len - 1), make_flit(v, c, p, i)});
      exp_q[v].push_back({(i == len - 1), make_flit(v, c, p, i)});
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    for (int v = 0; v < NUM_VC; v++) begin
      for (int c = 0; c < CH; c++) tx_q[v][c].delete();
      rx_q[v].delete();
      exp_q[v].delete();
    end
    vc_seq.delete();
    xfer_cyc.delete();
    @(negedge clk);
    rst = 1'b1;
    repeat (2) begin
      @(negedge clk);
      assert (!out_valid && vc0_in_ready == '0 && vc1_in_ready == '0) else begin
        $display("FAIL %0t: outputs active during reset", $time);
        value_errors++;
      end
    end
    rst = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // Timeout-bounded wait until every expected flit has left the link
  task automatic wait_drained(string name, int max_cycles);
    int n;
    n = 0;
    while (rx_q[0].size() + rx_q[1].size() < exp_q[0].size() + exp_q[1].size()) begin
      if (n == max_cycles) begin
        $display("Timeout in test %s: not all flits left the output port", name);
        other_errors++;
        break;
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic check_streams(string name);
    for (int v = 0; v < NUM_VC; v++) begin
      assert (rx_q[v].size() == exp_q[v].size()) else begin
        $display("FAIL %0t: %s vc%0d got %0d flits, expected %0d", $time, name, v,
                 rx_q[v].size(), exp_q[v].size());
        value_errors++;
      end
      for (int i = 0; i < rx_q[v].size() && i < exp_q[v].size(); i++) begin
        assert (rx_q[v][i] == exp_q[v][i]) else begin
          $display("FAIL %0t: %s vc%0d flit %0d got %h expected %h", $time, name, v, i,
                   rx_q[v][i], exp_q[v][i]);
          value_errors++;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_outputs_idle();
    apply_reset();
    repeat (3) begin
      @(negedge clk);
      assert (!out_valid && vc0_in_ready == '0 && vc1_in_ready == '0) else begin
        $display("FAIL %0t: outputs active after reset with no valid input", $time);
        value_errors++;
      end
    end
  endtask

  task automatic single_packet();
    apply_reset();
    send_packet(1, 2, 0, 4);
    wait_drained("single", 50);
    check_streams("single");
  endtask

  // Grant resets to channel 0, so channel 1 leads
  task automatic round_robin_order();
    apply_reset();
    send_packet(0, 1, 0, 3);
    send_packet(0, 2, 0, 3);
    send_packet(0, 3, 0, 3);
    send_packet(0, 0, 0, 3);
    wait_drained("round_robin", 100);
    check_streams("round_robin");
  endtask

  task automatic vc_interleave();
    apply_reset();
    send_packet(0, 0, 0, 8);
    send_packet(1, 0, 0, 8);
    wait_drained("interleave", 100);
    check_streams("interleave");
    // Preference starts at VC 0 and flips after each flit
    foreach (vc_seq[i]) begin
      assert (vc_seq[i] == i % 2) else begin
        $display("FAIL %0t: interleave flit %0d on vc%0d", $time, i, vc_seq[i]);
        value_errors++;
      end
      // Link busy every cycle while both VCs hold flits
      if (i > 0) begin
        assert (xfer_cyc[i] == xfer_cyc[i - 1] + 1) else begin
          $display("FAIL %0t: interleave idle cycle before flit %0d", $time, i);
          value_errors++;
        end
      end
    end
  endtask

  // Two rounds per channel, order 1 2 3 0 in each VC
  task automatic back_pressure();
    int len;
    apply_reset();
    stall_en = 1'b1;
    for (int p = 0; p < 2; p++) begin
      for (int k = 1; k <= CH; k++) begin
        for (int v = 0; v < NUM_VC; v++) begin
          len = ($unsigned($random(seed)) % 4) + 1;
          send_packet(v, k % CH, p, len);
        end
      end
    end
    wait_drained("back_pressure", 1000);
    check_streams("back_pressure");
    stall_en = 1'b0;
  endtask

  initial begin
    rst          = 1'b1;
    out_ready    = 1'b0;
    vc0_in_flit  = '0;
    vc0_in_last  = '0;
    vc0_in_valid = '0;
    vc1_in_flit  = '0;
    vc1_in_last  = '0;
    vc1_in_valid = '0;
    reset_outputs_idle();
    single_packet();
    round_robin_order();
    vc_interleave();
    back_pressure();
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_noc_output_port

`default_nettype wire

// File: tests/noc_output_port_properties.sv
// Port-level checks bound into the output port; stability check assumes sources hold their inputs
`default_nettype none
`timescale 1ns/1ps

module noc_output_port_properties #(
  parameter int CHANNELS   = 4,
  parameter int FLIT_WIDTH = 32
) (
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic [CHANNELS-1:0]   vc0_in_ready,
  input wire logic [CHANNELS-1:0]   vc1_in_ready,
  input wire logic [FLIT_WIDTH-1:0] out_flit,
  input wire logic                  out_last,
  input wire logic                  out_vc,
  input wire logic                  out_valid,
  input wire logic                  out_ready
);

  ////////////////////////////////////////
  // Link stall
  ////////////////////////////////////////

  // Stalled flit holds on the link
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_flit) && $stable(out_last) && $stable(out_vc))
    else $error("output changed while stalled");

  // No input accepted without link ready
  assert property (@(posedge clk)
    !out_ready |-> (vc0_in_ready == '0) && (vc1_in_ready == '0))
    else $error("in_ready high while out_ready low");

  ////////////////////////////////////////
  // Per-VC grant
  ////////////////////////////////////////

  assert property (@(posedge clk) $onehot0(vc0_in_ready) && $onehot0(vc1_in_ready))
    else $error("in_ready not one-hot within a VC");

endmodule : noc_output_port_properties

bind noc_output_port noc_output_port_properties #(
  .CHANNELS   (CHANNELS),
  .FLIT_WIDTH (FLIT_WIDTH)
) i_props (.*);

`default_nettype wire

// File: rtl/noc_output_port.sv
// Router output port top; zero-latency path, no buffering, CHANNELS must be 2 or more
`default_nettype none
`timescale 1ns/1ps

module noc_output_port import noc_flit_pkg::*; #(
  parameter int CHANNELS   = 4,
  parameter int FLIT_WIDTH = 32
) (
  input  wire logic                                clk,
  input  wire logic                                rst,

  // Request VC inputs
  input  wire logic [CHANNELS-1:0][FLIT_WIDTH-1:0] vc0_in_flit,
  input  wire logic [CHANNELS-1:0]                 vc0_in_last,
  input  wire logic [CHANNELS-1:0]                 vc0_in_valid,
  output logic      [CHANNELS-1:0]                 vc0_in_ready,

  // Response VC inputs
  input  wire logic [CHANNELS-1:0][FLIT_WIDTH-1:0] vc1_in_flit,
  input  wire logic [CHANNELS-1:0]                 vc1_in_last,
  input  wire logic [CHANNELS-1:0]                 vc1_in_valid,
  output logic      [CHANNELS-1:0]                 vc1_in_ready,

  // Physical link
  output logic      [FLIT_WIDTH-1:0]               out_flit,
  output logic                                     out_last,
  output vc_id_e                                   out_vc,
  output logic                                     out_valid,
  input  wire logic                                out_ready
);

  ////////////////////////////////////////
  // Mux to link arbiter, one lane per VC
  ////////////////////////////////////////

  logic [NUM_VC-1:0][FLIT_WIDTH-1:0] mux_flit;
  logic [NUM_VC-1:0]                 mux_last;
  logic [NUM_VC-1:0]                 mux_valid;
  logic [NUM_VC-1:0]                 mux_ready;

  // Request VC packet mux
  noc_packet_mux #(
    .CHANNELS   (CHANNELS),
    .FLIT_WIDTH (FLIT_WIDTH)
  ) i_mux_vc0 (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (vc0_in_flit),
    .in_last   (vc0_in_last),
    .in_valid  (vc0_in_valid),
    .in_ready  (vc0_in_ready),
    .out_flit  (mux_flit[0]),
    .out_last  (mux_last[0]),
    .out_valid (mux_valid[0]),
    .out_ready (mux_ready[0])
  );

  // Response VC packet mux
  noc_packet_mux #(
    .CHANNELS   (CHANNELS),
    .FLIT_WIDTH (FLIT_WIDTH)
  ) i_mux_vc1 (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (vc1_in_flit),
    .in_last   (vc1_in_last),
    .in_valid  (vc1_in_valid),
    .in_ready  (vc1_in_ready),
    .out_flit  (mux_flit[1]),
    .out_last  (mux_last[1]),
    .out_valid (mux_valid[1]),
    .out_ready (mux_ready[1])
  );

  ////////////////////////////////////////
  // Link arbiter
  ////////////////////////////////////////

  // Flit-level interleave, tags each flit with its VC
  noc_vc_link_arbiter #(
    .FLIT_WIDTH (FLIT_WIDTH)
  ) i_link (
    .clk       (clk),
    .rst       (rst),
    .vc0_flit  (mux_flit[0]),
    .vc0_last  (mux_last[0]),
    .vc0_valid (mux_valid[0]),
    .vc0_ready (mux_ready[0]),
    .vc1_flit  (mux_flit[1]),
    .vc1_last  (mux_last[1]),
    .vc1_valid (mux_valid[1]),
    .vc1_ready (mux_ready[1]),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_vc    (out_vc),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule : noc_output_port

`default_nettype wire

// File: rtl/noc_vc_link_arbiter.sv
// Flit-level merge of two VC streams; inputs must keep valid independent of ready
`default_nettype none
`timescale 1ns/1ps

module noc_vc_link_arbiter import noc_flit_pkg::*, noc_ctrl_pkg::*; #(
  parameter int FLIT_WIDTH = 32
) (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic [FLIT_WIDTH-1:0] vc0_flit,
  input  wire logic                  vc0_last,
  input  wire logic                  vc0_valid,
  output logic                       vc0_ready,

  input  wire logic [FLIT_WIDTH-1:0] vc1_flit,
  input  wire logic                  vc1_last,
  input  wire logic                  vc1_valid,
  output logic                       vc1_ready,

  output logic      [FLIT_WIDTH-1:0] out_flit,
  output logic                       out_last,
  output vc_id_e                     out_vc,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Who wins when both VCs have a flit
  link_pref_e pref;

  // Per-VC valids and the chosen VC, one-hot or zero
  logic [NUM_VC-1:0] vc_valid;
  logic [NUM_VC-1:0] vc_grant;
  logic              xfer;

  assign vc_valid = {vc1_valid, vc0_valid};

  ////////////////////////////////////////
  // VC selection
  ////////////////////////////////////////

  // Lone requester always wins
  // Conflict resolved by the preference register
  always_comb begin
    vc_grant = vc_valid;
    if (&vc_valid) begin
      if (pref == PREF_VC0) begin
        vc_grant[1] = 1'b0;
      end else begin
        vc_grant[0] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Link outputs
  ////////////////////////////////////////

  // VC 0 is the default leg of the mux
  assign out_flit  = vc_grant[1] ? vc1_flit : vc0_flit;
  assign out_last  = vc_grant[1] ? vc1_last : vc0_last;
  assign out_vc    = vc_grant[1] ? VC_RESP : VC_REQ;
  assign out_valid = |vc_valid;

  // Link ready goes to the chosen VC only
  assign vc0_ready = out_ready & vc_grant[0];
  assign vc1_ready = out_ready & vc_grant[1];

  assign xfer = out_valid & out_ready;

  // After each flit the other VC gets priority
  always_ff @(posedge clk) begin
    if (rst) begin
      pref <= PREF_VC0;
    end else if (xfer) begin
      pref <= vc_grant[1] ? PREF_VC0 : PREF_VC1;
    end
  end

endmodule : noc_vc_link_arbiter

`default_nettype wire

// File: rtl/noc_packet_mux.sv
// Per-VC packet mux; out_valid ignores out_ready, input is held from head flit until last flit
`default_nettype none
`timescale 1ns/1ps

module noc_packet_mux import noc_ctrl_pkg::*; #(
  parameter int CHANNELS   = 4,
  parameter int FLIT_WIDTH = 32
) (
  input  wire logic                                clk,
  input  wire logic                                rst,

  input  wire logic [CHANNELS-1:0][FLIT_WIDTH-1:0] in_flit,
  input  wire logic [CHANNELS-1:0]                 in_last,
  input  wire logic [CHANNELS-1:0]                 in_valid,
  output logic      [CHANNELS-1:0]                 in_ready,

  output logic      [FLIT_WIDTH-1:0]               out_flit,
  output logic                                     out_last,
  output logic                                     out_valid,
  input  wire logic                                out_ready
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Route lock state
  mux_state_e state;

  // Current one-hot grant, last channel that started a packet
  logic [CHANNELS-1:0] gnt;
  // Round-robin candidate for the next packet
  logic [CHANNELS-1:0] nxt_gnt;
  // Channel presented on the output this cycle
  logic [CHANNELS-1:0] select;
  // Flit moves on this edge
  logic                xfer;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Requests are raw valids
  // Gating by out_ready here would make valid depend on ready
  noc_rr_arbiter #(
    .N (CHANNELS)
  ) i_rr (
    .req     (in_valid),
    .gnt     (gnt),
    .nxt_gnt (nxt_gnt)
  );

  // Locked: stick with the packet owner
  assign select = (state == MUX_LOCKED) ? gnt : nxt_gnt;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // One-hot select, so an OR over the masked channels
  always_comb begin
    out_flit = '0;
    out_last = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (select[c]) begin
        out_flit = in_flit[c];
        out_last = in_last[c];
      end
    end
  end

  // Owner may stall mid packet, valid drops then
  assign out_valid = |(select & in_valid);

  // Ready back only to the selected, valid channel
  assign in_ready = select & in_valid & {CHANNELS{out_ready}};

  assign xfer = out_valid & out_ready;

  ////////////////////////////////////////
  // Lock and grant state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MUX_IDLE;
      gnt   <= CHANNELS'(1);
    end else if (xfer) begin
      // Grant moves only on a head flit
      if (state == MUX_IDLE) begin
        gnt <= nxt_gnt;
      end
      // Single-flit packet never locks
      state <= out_last ? MUX_IDLE : MUX_LOCKED;
    end
  end

endmodule : noc_packet_mux

`default_nettype wire

// File: rtl/noc_rr_arbiter.sv
// Combinational round robin; gnt must be one-hot or zero, nxt_gnt is zero when nothing requests
`default_nettype none
`timescale 1ns/1ps

module noc_rr_arbiter #(
  parameter int N = 4
) (
  input  wire logic [N-1:0] req,
  input  wire logic [N-1:0] gnt,
  output logic      [N-1:0] nxt_gnt
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Positions strictly above the current grant
  logic [N-1:0] upper_mask;
  // Requests that come after the grant in cyclic order
  logic [N-1:0] upper_req;
  // Vector the winner is taken from
  logic [N-1:0] search_req;

  ////////////////////////////////////////
  // Search
  ////////////////////////////////////////

  // Bits 0..k set for grant at bit k, then inverted
  // Grant on the top bit shifts out, so the mask goes empty
  // and the search wraps to channel 0
  // Zero grant also gives an empty mask
  assign upper_mask = ~((gnt << 1) - N'(1));

  assign upper_req = req & upper_mask;

  // No requester above the grant: wrap around
  // and search the full request vector from bit 0
  assign search_req = (|upper_req) ? upper_req : req;

  // Isolate lowest set bit (x & -x)
  // Result is one-hot, or zero with no requests
  assign nxt_gnt = search_req & (~search_req + N'(1));

endmodule : noc_rr_arbiter

`default_nettype wire

// File: rtl/noc_ctrl_pkg.sv
// Control state encodings for the output stage; both enums are 1 bit and reset to the first value
`default_nettype none

package noc_ctrl_pkg;

  ////////////////////////////////////////
  // Packet mux route lock
  ////////////////////////////////////////

  // Idle: free to pick a new input
  // Locked: bound to one input until its last flit
  typedef enum logic {
    MUX_IDLE   = 1'b0,
    MUX_LOCKED = 1'b1
  } mux_state_e;

  ////////////////////////////////////////
  // Link arbiter priority
  ////////////////////////////////////////

  // VC that wins the next conflict on the link
  typedef enum logic {
    PREF_VC0 = 1'b0,
    PREF_VC1 = 1'b1
  } link_pref_e;

endpackage : noc_ctrl_pkg

`default_nettype wire

// File: rtl/noc_flit_pkg.sv
// Link-level VC definitions; the design supports exactly two VCs and a 1-bit VC tag
`default_nettype none

package noc_flit_pkg;

  ////////////////////////////////////////
  // Virtual channels
  ////////////////////////////////////////

  // Number of VCs sharing the physical link
  localparam int NUM_VC = 2;

  // VC tag carried with every flit on the link
  // Requests and responses travel on separate VCs
  // to avoid protocol deadlock
  typedef enum logic {
    VC_REQ  = 1'b0,
    VC_RESP = 1'b1
  } vc_id_e;

endpackage : noc_flit_pkg

`default_nettype wire
